// ==== verilog/qdrc_config.svh ====
`ifndef QDRC_CONFIG_SVH
`define QDRC_CONFIG_SVH

// sram geometry, per clock edge
`define QDRC_DATA_WIDTH   18
// byte-write lanes of 9 bits
`define QDRC_BW_WIDTH     2
`define QDRC_ADDR_WIDTH   10

// input delay line and read latency search range
`define QDRC_TAP_MAX      32
`define QDRC_MAX_LATENCY  8

// settle time after the sram dll is switched on
`define QDRC_DLL_WAIT     64

// training pattern; burst alignment uses it inverted
`define QDRC_CAL_RISE     {`QDRC_DATA_WIDTH{1'b1}}
`define QDRC_CAL_FALL     {`QDRC_DATA_WIDTH{1'b0}}

`endif

// ==== verilog/qdrc_pkg.sv ====
package qdrc_pkg;
  `include "qdrc_config.svh"

  // one cycle worth of qdr pin outputs
  typedef struct packed {
    logic                          w_n;
    logic                          r_n;
    logic [`QDRC_ADDR_WIDTH-1:0]   sa;
    logic [`QDRC_DATA_WIDTH-1:0]   d_rise;
    logic [`QDRC_DATA_WIDTH-1:0]   d_fall;
    logic [`QDRC_BW_WIDTH-1:0]     bw_n_rise;
    logic [`QDRC_BW_WIDTH-1:0]     bw_n_fall;
  } qdr_cmd_t;

  typedef struct packed {
    logic [`QDRC_DATA_WIDTH-1:0]   q_rise;
    logic [`QDRC_DATA_WIDTH-1:0]   q_fall;
  } qdr_rsp_t;

  // per-bit strobes toward the input delay lines
  typedef struct packed {
    logic [`QDRC_DATA_WIDTH-1:0]   inc_dec_n;
    logic [`QDRC_DATA_WIDTH-1:0]   en;
    logic [`QDRC_DATA_WIDTH-1:0]   rst;
  } dly_ctrl_t;

  // no access, all byte lanes masked
  localparam qdr_cmd_t QDR_CMD_IDLE = '{
    w_n:       1'b1,
    r_n:       1'b1,
    sa:        '0,
    d_rise:    '0,
    d_fall:    '0,
    bw_n_rise: '1,
    bw_n_fall: '1
  };

  typedef enum logic [2:0] {ST_DLL_WAIT, ST_BIT_ALIGN, ST_BURST_ALIGN, ST_READY, ST_FAIL} phy_state_e;
  typedef enum logic [1:0] {OWN_NONE, OWN_BIT, OWN_BURST, OWN_USER} bus_owner_e;
  typedef enum logic [2:0] {BA_IDLE, BA_WRITE, BA_TAP_RST, BA_READ,
                            BA_STEP, BA_CENTER, BA_DEC, BA_NEXT} bit_align_state_e;
  typedef enum logic [2:0] {BU_IDLE, BU_WRITE, BU_READ, BU_WAIT, BU_ARM, BU_READY} burst_align_state_e;
endpackage

// ==== verilog/qdrc_phy_sm.sv ====
`timescale 1ns/100ps
`include "qdrc_config.svh"

module qdrc_phy_sm (
  input  logic                 clk0,
  input  logic                 arst_n,
  input  logic                 bit_align_done,
  input  logic                 bit_align_fail,
  input  logic                 burst_align_done,
  input  logic                 burst_align_fail,
  output logic                 bit_align_start,
  output logic                 burst_align_start,
  output qdrc_pkg::bus_owner_e owner,
  output logic                 qdr_dll_off_n,
  output logic                 phy_rdy,
  output logic                 cal_fail
);
  import qdrc_pkg::*;

  localparam int DLL_CNT_W = $clog2(`QDRC_DLL_WAIT);

  phy_state_e           state;
  logic [DLL_CNT_W-1:0] dll_cnt;

  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      state             <= ST_DLL_WAIT;
      dll_cnt           <= '0;
      qdr_dll_off_n     <= 1'b0;
      bit_align_start   <= 1'b0;
      burst_align_start <= 1'b0;
      phy_rdy           <= 1'b0;
      cal_fail          <= 1'b0;
    end else begin
      qdr_dll_off_n     <= 1'b1;  // dll on from the first edge
      bit_align_start   <= 1'b0;
      burst_align_start <= 1'b0;
      case (state)
        ST_DLL_WAIT: begin
          if (qdr_dll_off_n) begin
            dll_cnt <= dll_cnt + 1'b1;
            if (dll_cnt == DLL_CNT_W'(`QDRC_DLL_WAIT - 1)) begin
              state           <= ST_BIT_ALIGN;
              bit_align_start <= 1'b1;
            end
          end
        end
        ST_BIT_ALIGN: begin
          if (bit_align_fail) begin
            state    <= ST_FAIL;
            cal_fail <= 1'b1;
          end else if (bit_align_done) begin
            state             <= ST_BURST_ALIGN;
            burst_align_start <= 1'b1;
          end
        end
        ST_BURST_ALIGN: begin
          if (burst_align_fail) begin
            state    <= ST_FAIL;
            cal_fail <= 1'b1;
          end else if (burst_align_done) begin
            state   <= ST_READY;
            phy_rdy <= 1'b1;
          end
        end
        default: ;  // ready and fail are terminal
      endcase
    end
  end

  // pin bus ownership follows the phase
  always_comb begin
    case (state)
      ST_BIT_ALIGN:   owner = OWN_BIT;
      ST_BURST_ALIGN: owner = OWN_BURST;
      ST_READY:       owner = OWN_USER;
      default:        owner = OWN_NONE;
    endcase
  end
endmodule

// ==== verilog/qdrc_phy_bit_align.sv ====
`timescale 1ns/100ps
`include "qdrc_config.svh"

module qdrc_phy_bit_align (
  input  logic                clk0,
  input  logic                arst_n,
  input  logic                bit_align_start,
  input  qdrc_pkg::qdr_rsp_t  qdr_rsp,
  output logic                bit_align_done,
  output logic                bit_align_fail,
  output qdrc_pkg::qdr_cmd_t  bit_cmd,
  output qdrc_pkg::dly_ctrl_t dly,
  output qdrc_pkg::qdr_rsp_t  cal_rsp
);
  import qdrc_pkg::*;

  localparam int DW     = `QDRC_DATA_WIDTH;
  localparam int IDX_W  = $clog2(DW);
  localparam int TAP_W  = $clog2(`QDRC_TAP_MAX) + 1;
  localparam int RD_CYC = `QDRC_MAX_LATENCY + 3;  // read burst per tap, covers worst latency
  localparam int WAIT_W = $clog2(RD_CYC);
  localparam logic [DW-1:0] CAL_RISE = `QDRC_CAL_RISE;
  localparam logic [DW-1:0] CAL_FALL = `QDRC_CAL_FALL;

  bit_align_state_e  state;
  logic [IDX_W-1:0]  bit_idx;    // bit under calibration
  logic [TAP_W-1:0]  tap;        // mirror of that bit's delay tap
  logic [TAP_W-1:0]  first_tap;  // first tap inside the window
  logic [TAP_W-1:0]  win;        // matching taps seen so far
  logic [TAP_W-1:0]  center_tap;
  logic [WAIT_W-1:0] wait_cnt;
  logic              found;
  logic              hit;
  logic              last_wait;
  logic              top_tap;
  logic [DW-1:0]     bit_sel;

  assign hit        = (qdr_rsp.q_rise[bit_idx] == CAL_RISE[bit_idx]) &&
                      (qdr_rsp.q_fall[bit_idx] == CAL_FALL[bit_idx]);
  assign last_wait  = (wait_cnt == WAIT_W'(RD_CYC - 1));
  assign top_tap    = (tap == TAP_W'(`QDRC_TAP_MAX - 1));
  assign center_tap = first_tap + (win >> 1);
  assign bit_sel    = {{(DW-1){1'b0}}, 1'b1} << bit_idx;

  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      state          <= BA_IDLE;
      bit_idx        <= '0;
      tap            <= '0;
      first_tap      <= '0;
      win            <= '0;
      wait_cnt       <= '0;
      found          <= 1'b0;
      bit_align_done <= 1'b0;
      bit_align_fail <= 1'b0;
    end else begin
      bit_align_done <= 1'b0;
      bit_align_fail <= 1'b0;
      case (state)
        BA_IDLE: begin
          if (bit_align_start) begin
            state   <= BA_WRITE;
            bit_idx <= '0;
          end
        end
        BA_WRITE: state <= BA_TAP_RST;
        BA_TAP_RST: begin
          tap      <= '0;
          win      <= '0;
          found    <= 1'b0;
          wait_cnt <= '0;
          state    <= BA_READ;
        end
        BA_READ: begin
          wait_cnt <= wait_cnt + 1'b1;
          // sample at the end of the burst so the data belongs to this tap
          if (last_wait) begin
            wait_cnt <= '0;
            if (hit) begin
              win <= win + 1'b1;
              if (!found) begin
                found     <= 1'b1;
                first_tap <= tap;
              end
              state <= top_tap ? BA_CENTER : BA_STEP;
            end else if (found) begin
              state <= BA_CENTER;  // one past the window
            end else if (top_tap) begin
              bit_align_fail <= 1'b1;
              state          <= BA_IDLE;
            end else begin
              state <= BA_STEP;
            end
          end
        end
        BA_STEP: begin
          tap   <= tap + 1'b1;
          state <= BA_READ;
        end
        BA_CENTER: state <= (tap > center_tap) ? BA_DEC : BA_NEXT;
        BA_DEC: begin
          tap   <= tap - 1'b1;
          state <= BA_CENTER;  // back through center keeps en pulses apart
        end
        BA_NEXT: begin
          if (bit_idx == IDX_W'(DW - 1)) begin
            bit_align_done <= 1'b1;
            state          <= BA_IDLE;
          end else begin
            bit_idx <= bit_idx + 1'b1;
            state   <= BA_TAP_RST;
          end
        end
        default: state <= BA_IDLE;
      endcase
    end
  end

  // training traffic, always at address 0
  always_comb begin
    bit_cmd = QDR_CMD_IDLE;
    case (state)
      BA_WRITE: begin
        bit_cmd.w_n       = 1'b0;
        bit_cmd.d_rise    = CAL_RISE;
        bit_cmd.d_fall    = CAL_FALL;
        bit_cmd.bw_n_rise = '0;
        bit_cmd.bw_n_fall = '0;
      end
      BA_READ: bit_cmd.r_n = 1'b0;
      default: ;
    endcase
  end

  always_comb begin
    dly.inc_dec_n = {DW{state == BA_STEP}};
    dly.en        = (state == BA_STEP || state == BA_DEC) ? bit_sel : '0;
    dly.rst       = (state == BA_TAP_RST) ? bit_sel : '0;
  end

  // taps sit in the external delay line, data is already aligned here
  assign cal_rsp = qdr_rsp;
endmodule

// ==== verilog/qdrc_phy_burst_align.sv ====
`timescale 1ns/100ps
`include "qdrc_config.svh"

module qdrc_phy_burst_align (
  input  logic                            clk0,
  input  logic                            arst_n,
  input  logic                            burst_align_start,
  input  logic                            phy_rd_strb,
  input  qdrc_pkg::qdr_rsp_t              cal_rsp,
  output logic                            burst_align_done,
  output logic                            burst_align_fail,
  output qdrc_pkg::qdr_cmd_t              burst_cmd,
  output logic [2*`QDRC_DATA_WIDTH-1:0]   phy_rd_data,
  output logic                            phy_rd_valid
);
  import qdrc_pkg::*;

  localparam int DW      = `QDRC_DATA_WIDTH;
  // counted from the command cycle, so the arbiter stage is included
  localparam int LAT_MAX = `QDRC_MAX_LATENCY + 1;
  localparam int LAT_W   = $clog2(LAT_MAX + 1);
  localparam logic [DW-1:0] PAT_RISE = ~`QDRC_CAL_RISE;
  localparam logic [DW-1:0] PAT_FALL = ~`QDRC_CAL_FALL;

  burst_align_state_e state;
  logic [LAT_W-1:0]   cnt;
  logic [LAT_W-1:0]   lat_idx;  // delay tap into rd_sr
  logic [LAT_MAX-1:0] rd_sr;    // bit k set k+1 cycles after a strobe
  logic               arrived;

  assign arrived = (cal_rsp.q_rise == PAT_RISE) && (cal_rsp.q_fall == PAT_FALL);

  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      state            <= BU_IDLE;
      cnt              <= '0;
      lat_idx          <= '0;
      burst_align_done <= 1'b0;
      burst_align_fail <= 1'b0;
    end else begin
      burst_align_done <= 1'b0;
      burst_align_fail <= 1'b0;
      case (state)
        BU_IDLE:  if (burst_align_start) state <= BU_WRITE;
        BU_WRITE: state <= BU_READ;
        BU_READ: begin
          cnt   <= LAT_W'(1);
          state <= BU_WAIT;
        end
        BU_WAIT: begin
          if (arrived) begin
            lat_idx          <= cnt - 1'b1;
            burst_align_done <= 1'b1;
            state            <= BU_ARM;
          end else if (cnt == LAT_W'(LAT_MAX)) begin
            burst_align_fail <= 1'b1;
            state            <= BU_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        BU_ARM:   state <= BU_READY;  // lines up with the user owner
        BU_READY: state <= BU_READY;
        default:  state <= BU_IDLE;
      endcase
    end
  end

  // inverted pattern at address 1, then one read of it
  always_comb begin
    burst_cmd = QDR_CMD_IDLE;
    case (state)
      BU_WRITE: begin
        burst_cmd.w_n       = 1'b0;
        burst_cmd.sa        = `QDRC_ADDR_WIDTH'(1);
        burst_cmd.d_rise    = PAT_RISE;
        burst_cmd.d_fall    = PAT_FALL;
        burst_cmd.bw_n_rise = '0;
        burst_cmd.bw_n_fall = '0;
      end
      BU_READ: begin
        burst_cmd.r_n = 1'b0;
        burst_cmd.sa  = `QDRC_ADDR_WIDTH'(1);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      rd_sr        <= '0;
      phy_rd_valid <= 1'b0;
    end else begin
      rd_sr        <= {rd_sr[LAT_MAX-2:0], phy_rd_strb && (state == BU_READY)};
      phy_rd_valid <= rd_sr[lat_idx];
    end
  end

  always_ff @(posedge clk0) begin
    phy_rd_data <= {cal_rsp.q_fall, cal_rsp.q_rise};  // fall in the upper half
  end
endmodule

// ==== verilog/qdrc_phy_bus_arb.sv ====
`timescale 1ns/100ps

module qdrc_phy_bus_arb (
  input  logic                 clk0,
  input  logic                 arst_n,
  input  qdrc_pkg::bus_owner_e owner,
  input  qdrc_pkg::qdr_cmd_t   bit_cmd,
  input  qdrc_pkg::qdr_cmd_t   burst_cmd,
  input  qdrc_pkg::qdr_cmd_t   user_cmd,
  output qdrc_pkg::qdr_cmd_t   qdr_cmd
);
  import qdrc_pkg::*;

  qdr_cmd_t sel_cmd;

  always_comb begin
    case (owner)
      OWN_BIT:   sel_cmd = bit_cmd;
      OWN_BURST: sel_cmd = burst_cmd;
      OWN_USER:  sel_cmd = user_cmd;
      default:   sel_cmd = QDR_CMD_IDLE;  // nobody drives the sram
    endcase
  end

  // single register stage in front of the pins
  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      qdr_cmd <= QDR_CMD_IDLE;
    end else begin
      qdr_cmd <= sel_cmd;
    end
  end
endmodule

// ==== verilog/qdrc_phy.sv ====
`timescale 1ns/100ps
`include "qdrc_config.svh"

module qdrc_phy (
  input  logic                           clk0,
  input  logic                           arst_n,
  input  logic [`QDRC_ADDR_WIDTH-1:0]    phy_addr,
  input  logic                           phy_wr_strb,
  input  logic [2*`QDRC_DATA_WIDTH-1:0]  phy_wr_data,
  input  logic [2*`QDRC_BW_WIDTH-1:0]    phy_wr_ben,
  input  logic                           phy_rd_strb,
  input  qdrc_pkg::qdr_rsp_t             qdr_rsp,
  output logic                           phy_rdy,
  output logic                           cal_fail,
  output logic [2*`QDRC_DATA_WIDTH-1:0]  phy_rd_data,
  output logic                           phy_rd_valid,
  output qdrc_pkg::qdr_cmd_t             qdr_cmd,
  output logic                           qdr_dll_off_n,
  output qdrc_pkg::dly_ctrl_t            dly
);
  import qdrc_pkg::*;

  localparam int DW = `QDRC_DATA_WIDTH;
  localparam int BW = `QDRC_BW_WIDTH;

  logic       bit_align_start, bit_align_done, bit_align_fail;
  logic       burst_align_start, burst_align_done, burst_align_fail;
  bus_owner_e owner;
  qdr_cmd_t   bit_cmd;
  qdr_cmd_t   burst_cmd;
  qdr_cmd_t   user_cmd;
  qdr_rsp_t   cal_rsp;

  // user request mapped onto the pins, active-low enables
  always_comb begin
    user_cmd.w_n       = ~phy_wr_strb;
    user_cmd.r_n       = ~phy_rd_strb;
    user_cmd.sa        = phy_addr;
    user_cmd.d_rise    = phy_wr_data[DW-1:0];
    user_cmd.d_fall    = phy_wr_data[2*DW-1:DW];
    user_cmd.bw_n_rise = ~phy_wr_ben[BW-1:0];
    user_cmd.bw_n_fall = ~phy_wr_ben[2*BW-1:BW];
  end

  qdrc_phy_sm u_sm (
    .clk0              (clk0),
    .arst_n            (arst_n),
    .bit_align_done    (bit_align_done),
    .bit_align_fail    (bit_align_fail),
    .burst_align_done  (burst_align_done),
    .burst_align_fail  (burst_align_fail),
    .bit_align_start   (bit_align_start),
    .burst_align_start (burst_align_start),
    .owner             (owner),
    .qdr_dll_off_n     (qdr_dll_off_n),
    .phy_rdy           (phy_rdy),
    .cal_fail          (cal_fail)
  );

  qdrc_phy_bit_align u_bit_align (
    .clk0            (clk0),
    .arst_n          (arst_n),
    .bit_align_start (bit_align_start),
    .qdr_rsp         (qdr_rsp),
    .bit_align_done  (bit_align_done),
    .bit_align_fail  (bit_align_fail),
    .bit_cmd         (bit_cmd),
    .dly             (dly),
    .cal_rsp         (cal_rsp)
  );

  qdrc_phy_burst_align u_burst_align (
    .clk0              (clk0),
    .arst_n            (arst_n),
    .burst_align_start (burst_align_start),
    .phy_rd_strb       (phy_rd_strb),
    .cal_rsp           (cal_rsp),
    .burst_align_done  (burst_align_done),
    .burst_align_fail  (burst_align_fail),
    .burst_cmd         (burst_cmd),
    .phy_rd_data       (phy_rd_data),
    .phy_rd_valid      (phy_rd_valid)
  );

  qdrc_phy_bus_arb u_bus_arb (
    .clk0      (clk0),
    .arst_n    (arst_n),
    .owner     (owner),
    .bit_cmd   (bit_cmd),
    .burst_cmd (burst_cmd),
    .user_cmd  (user_cmd),
    .qdr_cmd   (qdr_cmd)
  );
endmodule

// ==== testbench/qdr_sram_model.sv ====
`timescale 1ns/100ps
`include "qdrc_config.svh"

module qdr_sram_model #(
  parameter int READ_LAT = 3
) (
  input  logic                            clk0,
  input  qdrc_pkg::qdr_cmd_t              qdr_cmd,
  input  qdrc_pkg::dly_ctrl_t             dly,
  input  logic [6*`QDRC_DATA_WIDTH-1:0]   win_start,  // 6 bits per data bit
  output qdrc_pkg::qdr_rsp_t              qdr_rsp,
  output logic [6*`QDRC_DATA_WIDTH-1:0]   taps
);
  import qdrc_pkg::*;

  localparam int DW    = `QDRC_DATA_WIDTH;
  localparam int DEPTH = 1 << `QDRC_ADDR_WIDTH;
  localparam int WIN   = 6;

  logic [2*DW-1:0] mem [DEPTH];      // {fall, rise}
  logic [2*DW-1:0] rd_word [READ_LAT];
  logic [5:0]      tap [DW];

  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = {a[9:0], ~a[9:0], a[9:0] ^ 10'h2b3, a[5:0]};  // whole address in the fill
    end
    for (int i = 0; i < DW; i++) begin
      tap[i] = '0;
    end
  end

  always @(posedge clk0) begin
    if (!qdr_cmd.w_n) begin
      for (int j = 0; j < `QDRC_BW_WIDTH; j++) begin
        if (!qdr_cmd.bw_n_rise[j]) mem[qdr_cmd.sa][j*9 +: 9] <= qdr_cmd.d_rise[j*9 +: 9];
        if (!qdr_cmd.bw_n_fall[j]) mem[qdr_cmd.sa][DW + j*9 +: 9] <= qdr_cmd.d_fall[j*9 +: 9];
      end
    end
    // data captured when the read is issued
    rd_word[0] <= !qdr_cmd.r_n ? mem[qdr_cmd.sa] : '0;
    for (int k = 1; k < READ_LAT; k++) begin
      rd_word[k] <= rd_word[k-1];
    end
    for (int i = 0; i < DW; i++) begin
      if (dly.rst[i]) tap[i] <= '0;
      else if (dly.en[i]) tap[i] <= dly.inc_dec_n[i] ? tap[i] + 1'b1 : tap[i] - 1'b1;
    end
  end

  always_comb begin
    logic in_win;
    for (int i = 0; i < DW; i++) begin
      in_win = (tap[i] >= win_start[i*6 +: 6]) && (tap[i] < win_start[i*6 +: 6] + WIN);
      qdr_rsp.q_rise[i] = rd_word[READ_LAT-1][i] ^ !in_win;  // inverted outside the window
      qdr_rsp.q_fall[i] = rd_word[READ_LAT-1][DW+i] ^ !in_win;
      taps[i*6 +: 6]    = tap[i];
    end
  end
endmodule

// ==== testbench/qdrc_phy_props.sv ====
`timescale 1ns/100ps

module qdrc_phy_props (
  input logic                 clk0,
  input logic                 arst_n,
  input qdrc_pkg::bus_owner_e owner,
  input qdrc_pkg::qdr_cmd_t   qdr_cmd,
  input logic                 phy_rdy,
  input logic                 cal_fail,
  input logic                 phy_rd_strb,
  input logic                 phy_rd_valid,
  input qdrc_pkg::dly_ctrl_t  dly
);
  import qdrc_pkg::*;

  logic seen_rd;  // some user read was accepted

  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) seen_rd <= 1'b0;
    else if (phy_rd_strb) seen_rd <= 1'b1;
  end

  idle_pins: assert property (@(posedge clk0) disable iff (!arst_n)
    owner == OWN_NONE |=> qdr_cmd.w_n && qdr_cmd.r_n)
    else $error("pins active with no bus owner");

  rdy_xor_fail: assert property (@(posedge clk0) disable iff (!arst_n)
    !(phy_rdy && cal_fail))
    else $error("ready and fail both high");

  valid_after_read: assert property (@(posedge clk0) disable iff (!arst_n)
    $rose(phy_rd_valid) |-> seen_rd)
    else $error("read valid without a read");

  en_single: assert property (@(posedge clk0) disable iff (!arst_n)
    (dly.en & $past(dly.en)) == '0)
    else $error("delay enable held longer than one cycle");
endmodule

bind qdrc_phy qdrc_phy_props u_props (
  .clk0         (clk0),
  .arst_n       (arst_n),
  .owner        (owner),
  .qdr_cmd      (qdr_cmd),
  .phy_rdy      (phy_rdy),
  .cal_fail     (cal_fail),
  .phy_rd_strb  (phy_rd_strb),
  .phy_rd_valid (phy_rd_valid),
  .dly          (dly)
);

// ==== testbench/qdrc_phy_tb.sv ====
`timescale 1ns/100ps
`include "qdrc_config.svh"

module qdrc_phy_tb;
  import qdrc_pkg::*;

  localparam int  DW = `QDRC_DATA_WIDTH;
  localparam int  AW = `QDRC_ADDR_WIDTH;
  localparam longint WD_CYCLES = DW * `QDRC_TAP_MAX * (`QDRC_MAX_LATENCY + 4) + 2000;

  logic            clk0 = 1'b0;
  logic            arst_n;
  logic [AW-1:0]   phy_addr;
  logic            phy_wr_strb;
  logic [2*DW-1:0] phy_wr_data;
  logic [3:0]      phy_wr_ben;
  logic            phy_rd_strb;
  qdr_rsp_t        qdr_rsp;
  logic            phy_rdy, cal_fail, phy_rd_valid, qdr_dll_off_n;
  logic [2*DW-1:0] phy_rd_data;
  qdr_cmd_t        qdr_cmd;
  dly_ctrl_t       dly;
  logic [6*DW-1:0] win_start;
  logic [6*DW-1:0] taps;

  logic [31:0]     lfsr = 32'hb74e765b;
  logic [2*DW-1:0] shadow [1 << AW];
  logic [AW-1:0]   addr_list [8];
  logic [2*DW-1:0] exp_q [$];
  logic            rsp_view = 1'b0;  // monitor compares in pin-response form
  int              errors = 0;

  always #10 clk0 = ~clk0;

  qdrc_phy u_dut (
    .clk0(clk0), .arst_n(arst_n), .phy_addr(phy_addr), .phy_wr_strb(phy_wr_strb),
    .phy_wr_data(phy_wr_data), .phy_wr_ben(phy_wr_ben), .phy_rd_strb(phy_rd_strb),
    .qdr_rsp(qdr_rsp), .phy_rdy(phy_rdy), .cal_fail(cal_fail), .phy_rd_data(phy_rd_data),
    .phy_rd_valid(phy_rd_valid), .qdr_cmd(qdr_cmd), .qdr_dll_off_n(qdr_dll_off_n), .dly(dly)
  );

  qdr_sram_model #(.READ_LAT(3)) u_sram (
    .clk0(clk0), .qdr_cmd(qdr_cmd), .dly(dly), .win_start(win_start),
    .qdr_rsp(qdr_rsp), .taps(taps)
  );

  task automatic take_bits(input int n, output logic [2*DW-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'ha3000000 : 32'h0);  // galois step
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_cmd(input string name, input qdr_cmd_t exp, input qdr_cmd_t act);
    if (exp !== act) begin
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_rsp(input string name, input qdr_rsp_t exp, input qdr_rsp_t act);
    if (exp !== act) begin
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input logic [2*DW-1:0] exp,
                            input logic [2*DW-1:0] act);
    if (exp !== act) begin
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic step();
    @(posedge clk0);
    #1;
  endtask

  // expected pin word for the request held on the inputs
  function automatic qdr_cmd_t pins_for(input logic w, input logic r, input logic [AW-1:0] a,
                                       input logic [2*DW-1:0] d, input logic [3:0] ben);
    qdr_cmd_t c;
    c.w_n       = !w;
    c.r_n       = !r;
    c.sa        = a;
    c.d_rise    = d[DW-1:0];
    c.d_fall    = d[2*DW-1:DW];
    c.bw_n_rise = ~ben[1:0];
    c.bw_n_fall = ~ben[3:2];
    return c;
  endfunction

  function automatic qdr_cmd_t idle_pins();
    return pins_for(1'b0, 1'b0, '0, '0, 4'h0);
  endfunction

  task automatic drive_idle();
    phy_wr_strb = 1'b0;
    phy_rd_strb = 1'b0;
    phy_wr_ben  = 4'h0;
    phy_wr_data = '0;
    phy_addr    = '0;
  endtask

  task automatic issue_write(input logic [AW-1:0] a, input logic [2*DW-1:0] d,
                             input logic [3:0] ben);
    qdr_cmd_t exp;
    exp         = pins_for(1'b1, 1'b0, a, d, ben);
    phy_addr    = a;
    phy_wr_data = d;
    phy_wr_ben  = ben;
    phy_wr_strb = 1'b1;
    phy_rd_strb = 1'b0;
    for (int k = 0; k < 4; k++) begin
      if (ben[k]) shadow[a][k*9 +: 9] = d[k*9 +: 9];
    end
    step();
    check_cmd("qdr_cmd", exp, qdr_cmd);
  endtask

  task automatic issue_read(input logic [AW-1:0] a);
    qdr_cmd_t exp;
    exp         = pins_for(1'b0, 1'b1, a, '0, 4'h0);
    phy_addr    = a;
    phy_wr_data = '0;
    phy_wr_ben  = 4'h0;
    phy_wr_strb = 1'b0;
    phy_rd_strb = 1'b1;
    exp_q.push_back(shadow[a]);
    step();
    check_cmd("qdr_cmd", exp, qdr_cmd);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 64) begin
      step();
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d reads never got a read valid", exp_q.size());
    end
  endtask

  // one expected word consumed per read valid
  always @(negedge clk0) begin
    logic [2*DW-1:0] e;
    qdr_rsp_t        er, ar;
    if (arst_n && phy_rd_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("read valid at %0t with no read outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        if (rsp_view) begin
          er.q_rise = e[DW-1:0];
          er.q_fall = e[2*DW-1:DW];
          ar.q_rise = phy_rd_data[DW-1:0];
          ar.q_fall = phy_rd_data[2*DW-1:DW];
          check_rsp("phy_rd_data", er, ar);
        end else begin
          check_data("phy_rd_data", e, phy_rd_data);
        end
      end
    end
  end

  task automatic apply_reset();
    arst_n = 1'b0;
    repeat (10) step();
    check_bit("phy_rdy", 1'b0, phy_rdy);
    check_bit("cal_fail", 1'b0, cal_fail);
    check_bit("phy_rd_valid", 1'b0, phy_rd_valid);
    check_bit("qdr_dll_off_n", 1'b0, qdr_dll_off_n);
    check_cmd("qdr_cmd", idle_pins(), qdr_cmd);
    arst_n = 1'b1;
    step();
    check_bit("phy_rdy", 1'b0, phy_rdy);
    check_bit("qdr_dll_off_n", 1'b1, qdr_dll_off_n);  // dll enabled on the first edge
    check_bit("qdr_cmd.w_n", 1'b1, qdr_cmd.w_n);
    check_bit("qdr_cmd.r_n", 1'b1, qdr_cmd.r_n);
    check_bit("dly.en", 1'b0, |dly.en);
    check_bit("dly.rst", 1'b0, |dly.rst);
  endtask

  task automatic calibration_test();
    int t, s;
    while (!phy_rdy && !cal_fail) step();
    check_bit("phy_rdy", 1'b1, phy_rdy);
    for (int i = 0; i < DW; i++) begin
      t = taps[i*6 +: 6];
      s = win_start[i*6 +: 6];
      if (t < s || t >= s + 6) begin
        errors++;
        $display("bit %0d parked at tap %0d outside window %0d..%0d", i, t, s, s + 5);
      end
    end
  endtask

  task automatic full_write_test();
    logic [2*DW-1:0] v, d;
    for (int i = 0; i < 8; i++) begin
      take_bits(AW, v);
      addr_list[i] = (v[AW-1:0] < 2) ? v[AW-1:0] + 2 : v[AW-1:0];
      take_bits(2*DW, d);
      issue_write(addr_list[i], d, 4'hf);
    end
    drive_idle();
    for (int i = 0; i < 8; i++) begin
      issue_read(addr_list[i]);
      drive_idle();
      step();
    end
    wait_drain();
  endtask

  task automatic partial_write_test();
    logic [2*DW-1:0] b, d;
    for (int i = 0; i < 8; i++) begin
      take_bits(4, b);
      take_bits(2*DW, d);
      issue_write(addr_list[i], d, (b[3:0] == 4'h0 || b[3:0] == 4'hf) ? 4'h5 : b[3:0]);
    end
    for (int i = 0; i < 8; i++) begin
      issue_read(addr_list[i]);
    end
    drive_idle();
    wait_drain();
  endtask

  task automatic pipelined_read_test();
    rsp_view = 1'b1;
    for (int i = 7; i >= 0; i--) begin
      issue_read(addr_list[i]);
    end
    drive_idle();
    wait_drain();
    rsp_view = 1'b0;
  endtask

  task automatic cal_failure_test();
    win_start[5:0] = 6'd40;  // bit 0 can never match
    apply_reset();
    while (!phy_rdy && !cal_fail) step();
    check_bit("cal_fail", 1'b1, cal_fail);
    check_bit("phy_rdy", 1'b0, phy_rdy);
    phy_wr_strb = 1'b1;
    phy_rd_strb = 1'b1;
    phy_wr_ben  = 4'hf;
    step();
    step();
    check_cmd("qdr_cmd", idle_pins(), qdr_cmd);
    drive_idle();
  endtask

  initial begin
    #(WD_CYCLES * 20);
    $display("run timed out after %0d cycles", WD_CYCLES);
    $display("test failed");
    $finish;
  end

  initial begin
    logic [2*DW-1:0] v;
    arst_n = 1'b0;
    drive_idle();
    for (int i = 0; i < DW; i++) begin
      take_bits(5, v);
      win_start[i*6 +: 6] = 6'(v % 27);
    end
    apply_reset();
    calibration_test();
    full_write_test();
    partial_write_test();
    pipelined_read_test();
    cal_failure_test();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end
endmodule

// ==== files.f ====
+incdir+verilog
verilog/qdrc_pkg.sv
verilog/qdrc_phy_sm.sv
verilog/qdrc_phy_bit_align.sv
verilog/qdrc_phy_burst_align.sv
verilog/qdrc_phy_bus_arb.sv
verilog/qdrc_phy.sv
testbench/qdr_sram_model.sv
testbench/qdrc_phy_props.sv
testbench/qdrc_phy_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= qdrc_phy_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
